// File: design/clock_settings.svh
`ifndef CLOCK_SETTINGS_SVH
`define CLOCK_SETTINGS_SVH

`default_nettype none

// clk cycles per second, scaled down for simulation
`define CLK_TICK_DIV 400
`define CLK_SCAN_DIV 4       // clk cycles per scan step

// wrap limits of the time fields
`define CLK_SEC_MAX 59
`define CLK_MIN_MAX 59
`define CLK_HR_MAX  23

`define CLK_DIGITS 6         // digits on the display

`default_nettype wire

`endif

// File: design/clock_pkg.sv
`default_nettype none

package clock_pkg;

	typedef logic [5:0] field_val_t;   // hours, minutes or seconds
	typedef logic [3:0] digit_t;       // one decimal digit
	typedef logic [6:0] seg_t;         // segment a in msb through g in lsb

	typedef enum logic {
		MODE_CLOCK,
		MODE_SET
	} mode_t;

	typedef enum logic [1:0] {
		FIELD_SEC,
		FIELD_MIN,
		FIELD_HR
	} field_t;

	// digit to segment pattern, blank for anything above 9
	function automatic seg_t seg_encode(input digit_t d);
		case (d)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: design/tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
	parameter int DIV = 4
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic o_tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;
	localparam logic [CW-1:0] CNT_LAST = CW'(DIV - 1);

	logic [CW-1:0] cnt;

	// free-running divider, one strobe per wrap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else begin
			if (cnt == CNT_LAST) begin
				cnt    <= '0;
				o_tick <= 1'b1;
			end else begin
				cnt    <= cnt + 1'b1;
				o_tick <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/time_keeper.sv
`timescale 1ns/1ps
`include "clock_settings.svh"
`default_nettype none

module time_keeper (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   i_sec_tick,
	input  wire                   i_mode_btn,
	input  wire                   i_field_btn,
	input  wire                   i_inc_btn,
	output clock_pkg::field_val_t o_sec,
	output clock_pkg::field_val_t o_min,
	output clock_pkg::field_val_t o_hr,
	output logic                  o_upd
);

	import clock_pkg::*;

	localparam field_val_t SEC_MAX = field_val_t'(`CLK_SEC_MAX);
	localparam field_val_t MIN_MAX = field_val_t'(`CLK_MIN_MAX);
	localparam field_val_t HR_MAX  = field_val_t'(`CLK_HR_MAX);

	mode_t      mode_q;
	field_t     field_q;
	field_val_t sec_nxt;
	field_val_t min_nxt;
	field_val_t hr_nxt;

	// step by one, back to zero past the limit
	function automatic field_val_t wrap_inc(input field_val_t v, input field_val_t max);
		return (v >= max) ? '0 : field_val_t'(v + 1'b1);
	endfunction

	// ------------------------------------------------------------------------
	// mode and field select
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q  <= MODE_CLOCK;
			field_q <= FIELD_SEC;
		end else begin
			if (i_mode_btn)
				mode_q <= (mode_q == MODE_CLOCK) ? MODE_SET : MODE_CLOCK;
			if (i_field_btn && mode_q == MODE_SET) begin   // field only moves while setting
				case (field_q)
					FIELD_SEC: field_q <= FIELD_MIN;
					FIELD_MIN: field_q <= FIELD_HR;
					default:   field_q <= FIELD_SEC;
				endcase
			end
		end
	end

	// ------------------------------------------------------------------------
	// next time value
	// ------------------------------------------------------------------------
	always_comb begin
		sec_nxt = o_sec;
		min_nxt = o_min;
		hr_nxt  = o_hr;
		if (mode_q == MODE_CLOCK) begin
			if (i_sec_tick) begin
				sec_nxt = wrap_inc(o_sec, SEC_MAX);
				if (o_sec >= SEC_MAX) begin            // carry into minutes
					min_nxt = wrap_inc(o_min, MIN_MAX);
					if (o_min >= MIN_MAX)
						hr_nxt = wrap_inc(o_hr, HR_MAX);
				end
			end
		end else if (i_inc_btn) begin
			// set mode steps one field, no carry
			case (field_q)
				FIELD_SEC: sec_nxt = wrap_inc(o_sec, SEC_MAX);
				FIELD_MIN: min_nxt = wrap_inc(o_min, MIN_MAX);
				default:   hr_nxt  = wrap_inc(o_hr, HR_MAX);
			endcase
		end
	end

	// time registers and the update strobe that travels with them
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec <= '0;
			o_min <= '0;
			o_hr  <= '0;
			o_upd <= 1'b0;
		end else begin
			o_sec <= sec_nxt;
			o_min <= min_nxt;
			o_hr  <= hr_nxt;
			o_upd <= (sec_nxt != o_sec) || (min_nxt != o_min) || (hr_nxt != o_hr);
		end
	end

endmodule

`default_nettype wire

// File: design/digit_buffer.sv
`timescale 1ns/1ps
`include "clock_settings.svh"
`default_nettype none

module digit_buffer (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire clock_pkg::field_val_t          i_sec,
	input  wire clock_pkg::field_val_t          i_min,
	input  wire clock_pkg::field_val_t          i_hr,
	input  wire                                 i_upd,
	output clock_pkg::seg_t [`CLK_DIGITS-1:0]   o_digit_seg
);

	import clock_pkg::*;

	localparam seg_t SEG_ZERO = seg_encode(digit_t'(0));

	seg_t [`CLK_DIGITS-1:0] code_nxt;

	function automatic digit_t tens(input field_val_t v);
		return digit_t'(v / 6'd10);
	endfunction

	function automatic digit_t ones(input field_val_t v);
		return digit_t'(v % 6'd10);
	endfunction

	// ------------------------------------------------------------------------
	// split and encode
	// ------------------------------------------------------------------------
	always_comb begin
		code_nxt[0] = seg_encode(ones(i_sec));
		code_nxt[1] = seg_encode(tens(i_sec));
		code_nxt[2] = seg_encode(ones(i_min));
		code_nxt[3] = seg_encode(tens(i_min));
		code_nxt[4] = seg_encode(ones(i_hr));
		code_nxt[5] = seg_encode(tens(i_hr));    // hour tens on the leftmost digit
	end

	// ------------------------------------------------------------------------
	// digit registers
	// ------------------------------------------------------------------------
	// all six load on the same edge so the scan never mixes two times
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_digit_seg <= {`CLK_DIGITS{SEG_ZERO}};   // 00:00:00
		else if (i_upd)
			o_digit_seg <= code_nxt;
	end

endmodule

`default_nettype wire

// File: design/seg_scan.sv
`timescale 1ns/1ps
`include "clock_settings.svh"
`default_nettype none

module seg_scan (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire                                 i_scan_tick,
	input  wire clock_pkg::seg_t [`CLK_DIGITS-1:0] i_digit_seg,
	output clock_pkg::seg_t                     o_seg,
	output logic [`CLK_DIGITS-1:0]              o_seg_enb
);

	localparam int IW = $clog2(`CLK_DIGITS);
	localparam logic [IW-1:0] IDX_LAST = IW'(`CLK_DIGITS - 1);

	logic [IW-1:0] scan_idx;    // slot currently lit

	// ------------------------------------------------------------------------
	// scan index
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx <= '0;
		end else if (i_scan_tick) begin
			if (scan_idx == IDX_LAST)
				scan_idx <= '0;
			else
				scan_idx <= scan_idx + 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// digit enable and segment mux
	// ------------------------------------------------------------------------
	always_comb begin
		o_seg_enb = ~(`CLK_DIGITS'(1) << scan_idx);   // one low bit per slot
		o_seg     = i_digit_seg[scan_idx];
	end

endmodule

`default_nettype wire

// File: design/clock_top.sv
`timescale 1ns/1ps
`include "clock_settings.svh"
`default_nettype none

module clock_top (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    i_mode_btn,
	input  wire                    i_field_btn,
	input  wire                    i_inc_btn,
	output clock_pkg::seg_t        o_seg,
	output logic [`CLK_DIGITS-1:0] o_seg_enb
);

	import clock_pkg::*;

	logic                   sec_tick;
	logic                   scan_tick;
	field_val_t             sec;
	field_val_t             min;
	field_val_t             hr;
	logic                   upd;
	seg_t [`CLK_DIGITS-1:0] digit_seg;

	// one strobe per second and one per scan step
	tick_gen #(.DIV(`CLK_TICK_DIV)) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	tick_gen #(.DIV(`CLK_SCAN_DIV)) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	time_keeper u_time_keeper (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_sec_tick  (sec_tick),
		.i_mode_btn  (i_mode_btn),
		.i_field_btn (i_field_btn),
		.i_inc_btn   (i_inc_btn),
		.o_sec       (sec),
		.o_min       (min),
		.o_hr        (hr),
		.o_upd       (upd)
	);

	digit_buffer u_digit_buffer (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_sec       (sec),
		.i_min       (min),
		.i_hr        (hr),
		.i_upd       (upd),
		.o_digit_seg (digit_seg)
	);

	seg_scan u_seg_scan (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_digit_seg (digit_seg),
		.o_seg       (o_seg),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

`default_nettype wire

// File: dv/clock_sva.sv
`timescale 1ns/1ps
`include "clock_settings.svh"
`default_nettype none

module clock_sva (
	input wire                        clk,
	input wire                        rst_n,
	input wire                        i_inc_btn,
	input wire clock_pkg::mode_t      i_mode,
	input wire clock_pkg::field_val_t i_sec,
	input wire clock_pkg::field_val_t i_min,
	input wire clock_pkg::field_val_t i_hr,
	input wire                        i_upd
);

	import clock_pkg::*;

	// fields stay inside their ranges
	a_sec_range: assert property (@(posedge clk) disable iff (!rst_n) i_sec <= `CLK_SEC_MAX)
		else $error("seconds above limit: %0d", i_sec);
	a_min_range: assert property (@(posedge clk) disable iff (!rst_n) i_min <= `CLK_MIN_MAX)
		else $error("minutes above limit: %0d", i_min);
	a_hr_range: assert property (@(posedge clk) disable iff (!rst_n) i_hr <= `CLK_HR_MAX)
		else $error("hours above limit: %0d", i_hr);

	// update strobe marks exactly the cycles with a new time
	a_upd_match: assert property (@(posedge clk) disable iff (!rst_n)
		i_upd == ((i_sec != $past(i_sec)) || (i_min != $past(i_min)) || (i_hr != $past(i_hr))))
		else $error("update strobe does not match a time change");

	a_set_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(i_mode == MODE_SET && !i_inc_btn) |=> $stable(i_sec))
		else $error("seconds moved in set mode without inc");

endmodule

bind time_keeper clock_sva u_clock_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.i_inc_btn (i_inc_btn),
	.i_mode    (mode_q),
	.i_sec     (o_sec),
	.i_min     (o_min),
	.i_hr      (o_hr),
	.i_upd     (o_upd)
);

`default_nettype wire

// File: dv/clock_tb.sv
`timescale 1ns/1ps
`include "clock_settings.svh"
`default_nettype none

module clock_tb;

	localparam int TICK_DIV  = `CLK_TICK_DIV;
	localparam int SCAN_DIV  = `CLK_SCAN_DIV;
	localparam int DIGITS    = `CLK_DIGITS;
	localparam int EDGE_GAP  = 30;                  // stay clear of a display change
	localparam int RUN_LIMIT = 120 * `CLK_TICK_DIV;

	logic              clk;
	logic              rst_n;
	logic              mode_btn;
	logic              field_btn;
	logic              inc_btn;
	logic [6:0]        seg;
	logic [DIGITS-1:0] seg_enb;

	// reference model state
	int         cyc;        // clk edges since reset release
	int         m_sec;
	int         m_min;
	int         m_hr;
	int         m_field;    // 0 sec, 1 min, 2 hr
	bit         m_set;
	int         d_sec;      // time the display should show
	int         d_min;
	int         d_hr;
	bit         tick_in;
	logic [9:0] seen_digits;
	bit         run_done;

	clock_top UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_mode_btn  (mode_btn),
		.i_field_btn (field_btn),
		.i_inc_btn   (inc_btn),
		.o_seg       (seg),
		.o_seg_enb   (seg_enb)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// reference functions
	// ------------------------------------------------------------------------
	function automatic logic [6:0] seg_of_digit(input int d);
		case (d)
			0:       return 7'b111_1110;
			1:       return 7'b011_0000;
			2:       return 7'b110_1101;
			3:       return 7'b111_1001;
			4:       return 7'b011_0011;
			5:       return 7'b101_1011;
			6:       return 7'b101_1111;
			7:       return 7'b111_0000;
			8:       return 7'b111_1111;
			9:       return 7'b111_0011;
			default: return 7'b000_0000;
		endcase
	endfunction

	function automatic int slot_digit(input int s, input int m, input int h, input int slot);
		case (slot)
			0:       return s % 10;
			1:       return s / 10;
			2:       return m % 10;
			3:       return m / 10;
			4:       return h % 10;
			default: return h / 10;   // hour tens on the leftmost digit
		endcase
	endfunction

	function automatic logic [DIGITS-1:0][6:0] display_codes(input int s, input int m,
			input int h);
		logic [DIGITS-1:0][6:0] codes;
		for (int k = 0; k < DIGITS; k++)
			codes[k] = seg_of_digit(slot_digit(s, m, h, k));
		return codes;
	endfunction

	// active low with only the lit slot's bit at zero
	function automatic logic [DIGITS-1:0] enable_of_slot(input int slot);
		logic [DIGITS-1:0] pat;
		for (int k = 0; k < DIGITS; k++)
			pat[k] = (k != slot);
		return pat;
	endfunction

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// ------------------------------------------------------------------------
	// time model stepped on every clk edge
	// ------------------------------------------------------------------------
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cyc     = 0;
			m_sec   = 0;
			m_min   = 0;
			m_hr    = 0;
			m_field = 0;
			m_set   = 1'b0;
			d_sec   = 0;
			d_min   = 0;
			d_hr    = 0;
		end else begin
			d_sec   = m_sec;    // buffer loads one cycle behind the counters
			d_min   = m_min;
			d_hr    = m_hr;
			tick_in = (cyc > 0) && (cyc % TICK_DIV == 0);
			cyc     = cyc + 1;
			if (!m_set && tick_in) begin
				m_sec = (m_sec + 1) % 60;
				if (m_sec == 0) begin
					m_min = (m_min + 1) % 60;
					if (m_min == 0)
						m_hr = (m_hr + 1) % 24;
				end
			end else if (m_set && inc_btn) begin
				case (m_field)
					0:       m_sec = (m_sec + 1) % 60;
					1:       m_min = (m_min + 1) % 60;
					default: m_hr  = (m_hr + 1) % 24;
				endcase
			end
			if (m_set && field_btn)
				m_field = (m_field + 1) % 3;
			if (mode_btn)
				m_set = !m_set;
		end
	end

	// ------------------------------------------------------------------------
	// display sampler
	// ------------------------------------------------------------------------
	initial begin : display_sampler
		int                     slot;
		int                     waited;
		int                     ph;
		logic [DIGITS-1:0]      prev_enb;
		logic [DIGITS-1:0][6:0] codes;
		slot     = 0;
		prev_enb = enable_of_slot(DIGITS - 1);
		waited   = 0;
		while (rst_n !== 1'b1) begin
			@(negedge clk);
			waited++;
			if (waited > 64) begin
				$display("reset was never released");
				abort_run();
			end
		end
		forever begin
			@(negedge clk);
			waited = 0;
			while (seg_enb !== enable_of_slot(slot)) begin
				compare_value("o_seg_enb", seg_enb, prev_enb);   // still on the last digit
				waited++;
				if (waited > 2 * SCAN_DIV) begin
					$display("digit enable never moved on to slot %0d", slot);
					abort_run();
				end
				@(negedge clk);
			end
			ph = (cyc + TICK_DIV - 2) % TICK_DIV;
			if (ph > EDGE_GAP && ph < TICK_DIV - EDGE_GAP) begin
				codes = display_codes(d_sec, d_min, d_hr);
				compare_value("o_seg", seg, codes[slot]);
				seen_digits[slot_digit(d_sec, d_min, d_hr, slot)] = 1'b1;
			end
			prev_enb = enable_of_slot(slot);
			slot     = (slot + 1) % DIGITS;
		end
	end

	initial begin : watchdog
		int n;
		n = 0;
		while (!run_done) begin
			@(negedge clk);
			n++;
			if (n > RUN_LIMIT) begin
				$display("run did not finish within %0d cycles", RUN_LIMIT);
				abort_run();
			end
		end
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	task automatic pulse_button(input int which);
		case (which)
			0:       mode_btn  = 1'b1;
			1:       field_btn = 1'b1;
			default: inc_btn   = 1'b1;
		endcase
		@(negedge clk);
		mode_btn  = 1'b0;
		field_btn = 1'b0;
		inc_btn   = 1'b0;
		@(negedge clk);
	endtask

	task automatic step_field(input int n);
		repeat (n) pulse_button(2);
		repeat (TICK_DIV) @(negedge clk);   // let the sampler see the result
	endtask

	task automatic set_field(input int f, input int target);
		int tries;
		int cur;
		int lim;
		tries = 0;
		while (m_field != f) begin
			pulse_button(1);
			tries++;
			if (tries > 3) begin
				$display("field select never reached field %0d", f);
				abort_run();
			end
		end
		cur = (f == 0) ? m_sec : (f == 1) ? m_min : m_hr;
		lim = (f == 2) ? 24 : 60;
		step_field((target - cur + lim) % lim);
	endtask

	initial begin : stimulus
		void'($urandom(32'hbdb2_a905));
		seen_digits = '0;
		rst_n       = 1'b0;
		mode_btn    = 1'b0;
		field_btn   = 1'b0;
		inc_btn     = 1'b0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		repeat (65 * TICK_DIV + TICK_DIV / 2) @(negedge clk);   // free run past 00:01:00

		pulse_button(0);                          // set mode
		repeat (3 * TICK_DIV) @(negedge clk);     // seconds hold
		step_field(60 - m_sec + int'($urandom % 10));   // always wraps 59 -> 00
		pulse_button(1);
		step_field(60 - m_min + int'($urandom % 10));
		pulse_button(1);
		step_field(24 - m_hr + int'($urandom % 10));
		pulse_button(1);                          // hr back to sec
		step_field(1 + int'($urandom % 5));

		set_field(0, 58);
		set_field(1, 59);
		set_field(2, 23);
		pulse_button(0);                          // back to clock mode to roll over midnight
		repeat (3 * TICK_DIV) @(negedge clk);

		run_done = 1'b1;
		if (seen_digits !== 10'h3ff) begin
			$display("not every digit was shown, seen mask %b", seen_digits);
			abort_run();
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/clock_pkg.sv
design/tick_gen.sv
design/time_keeper.sv
design/digit_buffer.sv
design/seg_scan.sv
design/clock_top.sv
dv/clock_sva.sv
dv/clock_tb.sv
